// ==== hdl/dedekindPkg.sv ====
package dedekindPkg;

    localparam int graphBits = 128;          // Vertices of the 7-cube.
    localparam int cubeDim = 7;
    localparam int countBits = 7;            // Counts up to 64.
    localparam int termBits = 65;            // Holds 2^64.

    typedef logic [graphBits-1:0] graphT;

    typedef struct packed {
        graphT                graph;          // Non-singleton remainder.
        logic [countBits-1:0] singletonCount;
        logic                 lastOfBatch;
    } graphItem;

    typedef struct packed {
        logic [countBits-1:0] componentCount;
        logic [countBits-1:0] singletonCount;
        logic                 lastOfBatch;
    } countResult;

    // Bit i of the result is bit (i ^ 2^d) of g.
    function automatic graphT flipDim(graphT g, int unsigned d);
        graphT r;
        for (int i = 0; i < graphBits; i++) begin
            r[i] = g[i ^ (1 << d)];
        end
        return r;
    endfunction

    // Vertices with at least one set neighbor in g.
    function automatic graphT cubeSpread(graphT g);
        graphT r;
        r = '0;
        for (int unsigned d = 0; d < cubeDim; d++) begin
            r |= flipDim(g, d);
        end
        return r;
    endfunction

endpackage

// ==== hdl/leafPrune.sv ====
`timescale 1ns/1ps

module leafPrune (
    input  logic               clk,
    input  logic               rstN,
    input  dedekindPkg::graphT sharedTop,
    input  dedekindPkg::graphT bot,
    input  logic               botValid,
    input  logic               lastBotOfBatch,
    output dedekindPkg::graphT prunedGraph,
    output logic               prunedValid,
    output logic               prunedLast
);
    import dedekindPkg::*;

    graphT maskedGraph;
    logic  maskedValid;
    logic  maskedLast;
    graphT leafMask;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            maskedValid <= 1'b0;
            maskedLast <= 1'b0;
            prunedValid <= 1'b0;
            prunedLast <= 1'b0;
        end else begin
            maskedValid <= botValid;
            maskedLast <= lastBotOfBatch & botValid;
            prunedValid <= maskedValid;
            prunedLast <= maskedLast;
        end
    end

    always_ff @(posedge clk) begin
        maskedGraph <= sharedTop & ~bot;
        prunedGraph <= maskedGraph & ~leafMask;
    end

    // A down leaf has one set neighbor, and that neighbor sits above it.
    always_comb begin : findLeaves
        graphT      nbr [cubeDim];
        logic [2:0] setCount;
        logic       lowerSet;
        for (int d = 0; d < cubeDim; d++) begin
            nbr[d] = flipDim(maskedGraph, d);
        end
        for (int i = 0; i < graphBits; i++) begin
            setCount = '0;
            lowerSet = 1'b0;
            for (int d = 0; d < cubeDim; d++) begin
                setCount = setCount + 3'(nbr[d][i]);
                if (i[d]) lowerSet = lowerSet | nbr[d][i];   // Neighbor is below.
            end
            leafMask[i] = maskedGraph[i] && (setCount == 3'd1) && !lowerSet;
        end
    end

    // A removed leaf keeps its upper neighbor, so no component is lost.
    leafKeepsNeighbor: assert property (@(posedge clk) disable iff (!rstN)
        maskedValid |=> (($past(maskedGraph) & ~prunedGraph & ~cubeSpread(prunedGraph))
                         == '0));

endmodule

// ==== hdl/singletonStrip.sv ====
`timescale 1ns/1ps

module singletonStrip (
    input  logic                  clk,
    input  logic                  rstN,
    input  dedekindPkg::graphT    prunedGraph,
    input  logic                  prunedValid,
    input  logic                  prunedLast,
    output dedekindPkg::graphItem item,
    output logic                  itemValid
);
    import dedekindPkg::*;

    graphT                spread;
    graphT                isolated;
    logic [countBits-1:0] isolatedCount;

    assign spread = cubeSpread(prunedGraph);
    assign isolated = prunedGraph & ~spread;          // Set with no set neighbor.
    assign isolatedCount = countBits'($countones(isolated));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            itemValid <= 1'b0;
        end else begin
            itemValid <= prunedValid;
        end
    end

    always_ff @(posedge clk) begin
        item.graph <= prunedGraph & spread;
        item.singletonCount <= isolatedCount;
        item.lastOfBatch <= prunedLast;
    end

    // Dropping isolated vertices cannot isolate others.
    noIsolatedLeft: assert property (@(posedge clk) disable iff (!rstN)
        itemValid |-> ((item.graph & ~cubeSpread(item.graph)) == '0));

endmodule

// ==== hdl/graphFifo.sv ====
`timescale 1ns/1ps

module graphFifo #(
    parameter int FifoDepth = 16
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  dedekindPkg::graphItem item,
    input  logic                  itemValid,
    input  logic                  pop,
    output dedekindPkg::graphItem headItem,
    output logic                  empty,
    output logic                  almostFull
);
    import dedekindPkg::*;

    localparam int PtrBits = $clog2(FifoDepth);

    graphItem           mem [FifoDepth];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits:0]   occupancy;

    always_ff @(posedge clk) begin
        if (itemValid) mem[wrPtr] <= item;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
        end else begin
            if (itemValid) wrPtr <= wrPtr + 1'b1;   // Wraps at the power of two.
            if (pop) rdPtr <= rdPtr + 1'b1;
            case ({itemValid, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign headItem = mem[rdPtr];
    assign empty = (occupancy == '0);
    // Room for the three front stages plus one.
    assign almostFull = (occupancy >= (PtrBits+1)'(FifoDepth - 4));

    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        itemValid |-> (occupancy < (PtrBits+1)'(FifoDepth)));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        pop |-> !empty);

endmodule

// ==== hdl/componentCounter.sv ====
`timescale 1ns/1ps

module componentCounter (
    input  logic                    clk,
    input  logic                    rstN,
    input  dedekindPkg::graphItem   headItem,
    input  logic                    empty,
    input  logic                    freezeCore,
    output logic                    pop,
    output dedekindPkg::countResult result,
    output logic                    resultValid
);
    import dedekindPkg::*;

    logic                 busy;
    graphT                remaining;
    graphT                flood;
    graphT                grown;
    graphT                rest;
    graphT                nextSeed;
    graphT                loadSeed;
    logic [countBits-1:0] componentCount;
    logic [countBits-1:0] singletonCount;
    logic                 lastOfBatch;
    logic                 done;

    assign pop = !busy && !empty && !freezeCore;
    assign done = busy && (remaining == '0);

    // One flood step over all seven dimensions.
    assign grown = (flood | cubeSpread(flood)) & remaining;
    assign rest = remaining & ~flood;
    assign nextSeed = rest & (~rest + 1'b1);                         // Lowest set vertex.
    assign loadSeed = headItem.graph & (~headItem.graph + 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= done;
            if (pop) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            remaining <= headItem.graph;
            flood <= loadSeed;
            componentCount <= '0;
            singletonCount <= headItem.singletonCount;
            lastOfBatch <= headItem.lastOfBatch;
        end else if (done) begin
            result.componentCount <= componentCount;
            result.singletonCount <= singletonCount;
            result.lastOfBatch <= lastOfBatch;
        end else if (busy) begin
            if (grown == flood) begin                               // Component complete.
                remaining <= rest;
                flood <= nextSeed;
                componentCount <= componentCount + 1'b1;
            end else begin
                flood <= grown;
            end
        end
    end

    // A job with vertices left always has a seed to grow.
    floodSeeded: assert property (@(posedge clk) disable iff (!rstN)
        (busy && (remaining != '0)) |-> (flood != '0));

endmodule

// ==== hdl/pcoeffAccumulator.sv ====
`timescale 1ns/1ps

module pcoeffAccumulator #(
    parameter int BatchCountBits = 8
) (
    input  logic                                             clk,
    input  logic                                             rstN,
    input  dedekindPkg::countResult                          result,
    input  logic                                             resultValid,
    input  logic                                             clearSums,
    output logic [dedekindPkg::termBits+BatchCountBits-1:0] pcoeffSum,
    output logic [BatchCountBits-1:0]                        pcoeffCount,
    output logic                                             batchValid
);
    import dedekindPkg::*;

    localparam int SumBits = termBits + BatchCountBits;

    logic [countBits:0]        exponent;
    logic [termBits-1:0]       term;
    logic [SumBits-1:0]        runSum;
    logic [SumBits-1:0]        nextSum;
    logic [BatchCountBits-1:0] runCount;
    logic [BatchCountBits-1:0] nextCount;

    assign exponent = result.componentCount + result.singletonCount;
    assign term = termBits'(1) << exponent;
    assign nextSum = runSum + SumBits'(term);
    assign nextCount = runCount + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runSum <= '0;
            runCount <= '0;
            pcoeffSum <= '0;
            pcoeffCount <= '0;
            batchValid <= 1'b0;
        end else begin
            batchValid <= 1'b0;
            if (resultValid && result.lastOfBatch) begin
                pcoeffSum <= nextSum;                // Final totals of the batch.
                pcoeffCount <= nextCount;
                batchValid <= 1'b1;
                runSum <= '0;
                runCount <= '0;
            end else if (clearSums) begin
                runSum <= '0;
                runCount <= '0;
            end else if (resultValid) begin
                runSum <= nextSum;
                runCount <= nextCount;
            end
        end
    end

    // Components and singletons of one cube graph never exceed 64.
    exponentInRange: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> (exponent <= (countBits+1)'(64)));

endmodule

// ==== hdl/aggregatingPipeline.sv ====
`timescale 1ns/1ps

module aggregatingPipeline #(
    parameter int FifoDepth = 16,
    parameter int BatchCountBits = 8
) (
    input  logic                                             clk,
    input  logic                                             rstN,
    input  dedekindPkg::graphT                               sharedTop,
    input  dedekindPkg::graphT                               bot,
    input  logic                                             botValid,
    input  logic                                             lastBotOfBatch,
    input  logic                                             freezeCore,
    input  logic                                             clearSums,
    output logic                                             almostFull,
    output logic                                             batchValid,
    output logic [dedekindPkg::termBits+BatchCountBits-1:0] pcoeffSum,
    output logic [BatchCountBits-1:0]                        pcoeffCount
);
    import dedekindPkg::*;

    graphT      prunedGraph;
    logic       prunedValid;
    logic       prunedLast;
    graphItem   item;
    logic       itemValid;
    graphItem   headItem;
    logic       empty;
    logic       pop;
    countResult result;
    logic       resultValid;

    leafPrune u_leafPrune (
        .clk(clk), .rstN(rstN),
        .sharedTop(sharedTop), .bot(bot),
        .botValid(botValid), .lastBotOfBatch(lastBotOfBatch),
        .prunedGraph(prunedGraph), .prunedValid(prunedValid), .prunedLast(prunedLast)
    );

    singletonStrip u_singletonStrip (
        .clk(clk), .rstN(rstN),
        .prunedGraph(prunedGraph), .prunedValid(prunedValid), .prunedLast(prunedLast),
        .item(item), .itemValid(itemValid)
    );

    graphFifo #(.FifoDepth(FifoDepth)) u_graphFifo (
        .clk(clk), .rstN(rstN),
        .item(item), .itemValid(itemValid), .pop(pop),
        .headItem(headItem), .empty(empty), .almostFull(almostFull)
    );

    componentCounter u_componentCounter (
        .clk(clk), .rstN(rstN),
        .headItem(headItem), .empty(empty), .freezeCore(freezeCore),
        .pop(pop), .result(result), .resultValid(resultValid)
    );

    pcoeffAccumulator #(.BatchCountBits(BatchCountBits)) u_pcoeffAccumulator (
        .clk(clk), .rstN(rstN),
        .result(result), .resultValid(resultValid), .clearSums(clearSums),
        .pcoeffSum(pcoeffSum), .pcoeffCount(pcoeffCount), .batchValid(batchValid)
    );

endmodule

// ==== test/tbRefModel.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Clears set vertices whose only set neighbor has a higher index.
function automatic graphT refPrune(graphT g);
    graphT r;
    int    setCount;
    int    upperCount;
    r = g;
    for (int i = 0; i < graphBits; i++) begin
        setCount = 0;
        upperCount = 0;
        for (int d = 0; d < cubeDim; d++) begin
            if (g[i ^ (1 << d)]) begin
                setCount++;
                if ((i ^ (1 << d)) > i) upperCount++;
            end
        end
        if (g[i] && setCount == 1 && upperCount == 1) r[i] = 1'b0;
    end
    return r;
endfunction

// Set vertices that have no set neighbor.
function automatic graphT refIsolated(graphT g);
    graphT r;
    r = '0;
    for (int i = 0; i < graphBits; i++) begin
        if (g[i]) begin
            r[i] = 1'b1;
            for (int d = 0; d < cubeDim; d++) begin
                if (g[i ^ (1 << d)]) r[i] = 1'b0;
            end
        end
    end
    return r;
endfunction

// Depth-first search over the cube edges.
function automatic int refComponents(graphT g);
    graphT seen;
    int    stack[$];
    int    count;
    int    v;
    int    w;
    seen = '0;
    count = 0;
    for (int i = 0; i < graphBits; i++) begin
        if (g[i] && !seen[i]) begin
            count++;
            seen[i] = 1'b1;
            stack.push_back(i);
            while (stack.size() > 0) begin
                v = stack.pop_back();
                for (int d = 0; d < cubeDim; d++) begin
                    w = v ^ (1 << d);
                    if (g[w] && !seen[w]) begin
                        seen[w] = 1'b1;
                        stack.push_back(w);
                    end
                end
            end
        end
    end
    return count;
endfunction

// Term 2^(components + singletons) of one masked graph.
function automatic logic [termBits-1:0] refTerm(graphT top, graphT bt);
    graphT               pruned;
    graphT               isolated;
    int                  n;
    logic [termBits-1:0] t;
    pruned = refPrune(top & ~bt);
    isolated = refIsolated(pruned);
    n = $countones(isolated) + refComponents(pruned & ~isolated);
    t = '0;
    t[n] = 1'b1;
    return t;
endfunction

`endif

// ==== test/tbAggregatingPipeline.sv ====
`timescale 1ns/1ps

module tbAggregatingPipeline;
    import dedekindPkg::*;

    `include "tbRefModel.svh"

    localparam int CountBits = 8;
    localparam int SumBits = termBits + CountBits;
    localparam int FifoDepth = 16;

    logic                 clk;
    logic                 rstN;
    graphT                sharedTop;
    graphT                bot;
    logic                 botValid;
    logic                 lastBotOfBatch;
    logic                 freezeCore;
    logic                 clearSums;
    logic                 almostFull;
    logic                 batchValid;
    logic [SumBits-1:0]   pcoeffSum;
    logic [CountBits-1:0] pcoeffCount;

    logic [SumBits-1:0]   runSum;
    logic [CountBits-1:0] runCount;
    logic [SumBits-1:0]   expSumQ[$];
    logic [CountBits-1:0] expCountQ[$];
    int                   errorCount;
    int                   checkCount;
    int                   testIndex;
    int                   testErrors;
    int                   cycleCount;
    int                   cycleLimit = 2000;
    bit                   sendingDone;

    aggregatingPipeline u_dut (
        .clk(clk), .rstN(rstN),
        .sharedTop(sharedTop), .bot(bot),
        .botValid(botValid), .lastBotOfBatch(lastBotOfBatch),
        .freezeCore(freezeCore), .clearSums(clearSums),
        .almostFull(almostFull), .batchValid(batchValid),
        .pcoeffSum(pcoeffSum), .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    function automatic graphT randomGraph();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // One graph, sent only while the FIFO has room.
    task automatic sendGraph(input graphT top, input graphT bt, input bit last);
        @(posedge clk);
        while (almostFull) @(posedge clk);
        sharedTop <= top;
        bot <= bt;
        botValid <= 1'b1;
        lastBotOfBatch <= last;
        runSum += SumBits'(refTerm(top, bt));
        runCount++;
        cycleLimit += 200;                   // Worst-case flood per graph.
        if (last) begin
            expSumQ.push_back(runSum);
            expCountQ.push_back(runCount);
            runSum = '0;
            runCount = '0;
        end
        @(posedge clk);
        botValid <= 1'b0;
        lastBotOfBatch <= 1'b0;
    endtask

    task automatic sendRandomBatch(input int len);
        for (int i = 0; i < len; i++) begin
            sendGraph(randomGraph(), randomGraph(), i == len - 1);
        end
    endtask

    task automatic finishTest(input string name);
        while (expSumQ.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        testIndex++;
        $display("Test %0d (%s) finished with %0d errors", testIndex, name,
                 errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // Scoreboard.
    always @(posedge clk) begin
        if (rstN && batchValid) begin
            if (expSumQ.size() == 0) begin
                $display("Error at %0t ns: batchValid arrived with no batch expected", $time);
                errorCount++;
            end else begin
                checkValue("pcoeffSum", 128'(pcoeffSum), 128'(expSumQ.pop_front()));
                checkValue("pcoeffCount", 128'(pcoeffCount), 128'(expCountQ.pop_front()));
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles with %0d batches still expected",
                 cycleCount, expSumQ.size());
        $display("Testbench failed");
        $finish;
    end

    initial begin
        graphT top;
        graphT evenGraph;
        int    span;
        errorCount = 0;
        checkCount = 0;
        testIndex = 0;
        testErrors = 0;
        cycleCount = 0;
        runSum = '0;
        runCount = '0;
        sendingDone = 1'b0;
        void'($urandom(32'hdb4e));
        rstN <= 1'b0;
        sharedTop <= '0;
        bot <= '0;
        botValid <= 1'b0;
        lastBotOfBatch <= 1'b0;
        freezeCore <= 1'b0;
        clearSums <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        // Every vertex masked off, so each graph is worth one.
        for (int b = 1; b <= 5; b += 4) begin
            for (int i = 0; i < b; i++) begin
                top = randomGraph();
                sendGraph(top, top, i == b - 1);
            end
        end
        finishTest("empty graphs");

        for (int i = 0; i < graphBits; i++) begin
            evenGraph[i] = ~^i[6:0];
        end
        sendGraph(graphT'(1) << 5, '0, 1'b0);
        sendGraph(graphT'(128'h3), '0, 1'b0);
        sendGraph(graphT'(128'h8b), '0, 1'b0);       // Path 0-1-3-7.
        sendGraph(graphT'(128'h17), '0, 1'b1);       // Star around vertex 0.
        sendGraph(evenGraph, '0, 1'b0);              // 64 singletons.
        sendGraph('1, '0, 1'b0);
        sendGraph(graphT'(128'h3) | (graphT'(128'h3) << 126), '0, 1'b1);
        finishTest("singletons and leaf chains");

        for (int b = 0; b < 10; b++) begin
            sendRandomBatch($urandom_range(1, 6));
        end
        finishTest("random batches");

        fork
            begin
                for (int b = 0; b < 8; b++) begin
                    sendRandomBatch($urandom_range(1, 6));
                end
                sendingDone = 1'b1;
            end
            begin
                while (!sendingDone) begin
                    span = $urandom_range(40, 120);
                    cycleLimit += span;
                    freezeCore <= 1'b1;
                    repeat (span) @(posedge clk);
                    freezeCore <= 1'b0;
                    repeat ($urandom_range(5, 20)) @(posedge clk);
                end
            end
        join
        finishTest("back-pressure");

        // With the counter frozen and idle, every written graph stays in the FIFO.
        freezeCore <= 1'b1;
        for (int i = 0; i < FifoDepth - 4; i++) begin
            top = randomGraph();
            sendGraph(top, randomGraph(), i == FifoDepth - 5);
            repeat (4) @(posedge clk);       // Front stages plus the FIFO write.
            checkValue("almostFull", 128'(almostFull), 128'(i + 1 >= FifoDepth - 4));
        end
        freezeCore <= 1'b0;
        finishTest("almostFull level");

        sendRandomBatch(3);
        while (expSumQ.size() != 0) @(posedge clk);
        // Two empty graphs of a batch that the clear abandons.
        top = randomGraph();
        sendGraph(top, top, 1'b0);
        sendGraph(top, top, 1'b0);
        repeat (10) @(posedge clk);          // Fixed path of an empty graph.
        clearSums <= 1'b1;
        @(posedge clk);
        clearSums <= 1'b0;
        runSum = '0;
        runCount = '0;
        sendRandomBatch(4);
        sendRandomBatch(2);
        while (expSumQ.size() != 0) @(posedge clk);
        clearSums <= 1'b1;
        @(posedge clk);
        clearSums <= 1'b0;
        sendRandomBatch(1);
        finishTest("clear between batches");

        $display("Summary: %0d tests, %0d checks, %0d errors", testIndex, checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+test
hdl/dedekindPkg.sv
hdl/leafPrune.sv
hdl/singletonStrip.sv
hdl/graphFifo.sv
hdl/componentCounter.sv
hdl/pcoeffAccumulator.sv
hdl/aggregatingPipeline.sv
test/tbAggregatingPipeline.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tbAggregatingPipeline
RTL_TOP    := aggregatingPipeline
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
LOG        := sim.log
FAIL_MSG   := Testbench failed
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
